// ==== verilog/mem_config.svh ====
// Sizes and latencies of the memory model; data width a multiple of 8, both latencies at least 1
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define MEM_DATA_W 32
`define MEM_ADDR_W 12
`define MEM_ID_W   4
`define MEM_LEN_W  8

// Derived sizes, byte offset dropped from the address
`define MEM_STRB_W (`MEM_DATA_W / 8)
`define MEM_IDX_W  (`MEM_ADDR_W - $clog2(`MEM_STRB_W))
`define MEM_WORDS  (1 << `MEM_IDX_W)

// ------------------------------
// Buffering and latency
// ------------------------------
`define MEM_CMD_DEPTH 4
`define MEM_WR_LAT    4
`define MEM_RD_LAT    4

`endif

// ==== verilog/axi_pkg.sv ====
// AXI4 channel payloads; burst type and size are implied (INCR, full width), resp is always OKAY
`include "mem_config.svh"

package axi_pkg;

  // ------------------------------
  // Response codes
  // ------------------------------
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // ------------------------------
  // Channel payloads
  // ------------------------------
  // Burst command, same layout for AW and AR
  typedef struct packed {
    logic [`MEM_ID_W-1:0]   id;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_LEN_W-1:0]  len;
  } cmd_t;

  typedef struct packed {
    logic [`MEM_DATA_W-1:0] data;
    logic [`MEM_STRB_W-1:0] strb;
    logic                   last;
  } w_beat_t;

  typedef struct packed {
    logic [`MEM_ID_W-1:0] id;
    logic [1:0]           resp;
  } b_resp_t;

  typedef struct packed {
    logic [`MEM_ID_W-1:0]   id;
    logic [`MEM_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic                   last;
  } r_beat_t;

endpackage

// ==== verilog/mem_pkg.sv ====
// Word array side types; indices count full-width words and wrap at the memory size
`include "mem_config.svh"

package mem_pkg;

  // ------------------------------
  // Array access
  // ------------------------------
  typedef logic [`MEM_IDX_W-1:0] word_idx_t;

  // One write per cycle, bytes merged under strb
  typedef struct packed {
    logic                   en;
    word_idx_t              idx;
    logic [`MEM_DATA_W-1:0] data;
    logic [`MEM_STRB_W-1:0] strb;
  } ram_wr_t;

  // Read data comes back in the same cycle
  typedef struct packed {
    word_idx_t idx;
  } ram_rd_t;

endpackage

// ==== verilog/cmd_fifo.sv ====
// Command FIFO, DEPTH >= 1; no bypass path, so a pushed entry shows at the output a cycle later
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int WIDTH = 24,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] in_data_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  output logic [WIDTH-1:0] out_data_o,
  output logic             out_valid_o,
  input  logic             out_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] buf_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Circular wrap, DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready_o  = (count != CNT_W'(DEPTH));
  assign out_valid_o = (count != '0);
  assign out_data_o  = buf_q[rd_ptr];
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= ptr_next(wr_ptr);
      if (pop)
        rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      buf_q[wr_ptr] <= in_data_i;
  end

  a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= CNT_W'(DEPTH))
    else $error("cmd_fifo count above DEPTH");

endmodule

// ==== verilog/wr_burst_engine.sv ====
// Write burst engine; one INCR burst at a time, len+1 full-width beats, word index wraps at top
`timescale 1ns/1ps
`include "mem_config.svh"

module wr_burst_engine (
  input  logic             clk,
  input  logic             rst,
  input  axi_pkg::cmd_t    cmd_i,
  input  logic             cmd_valid_i,
  output logic             cmd_ready_o,
  input  axi_pkg::w_beat_t w_i,
  input  logic             w_valid_i,
  output logic             w_ready_o,
  output mem_pkg::ram_wr_t ram_wr_o,
  output axi_pkg::b_resp_t b_o,
  output logic             b_valid_o,
  input  logic             b_ready_i
);

  logic                  busy;
  axi_pkg::cmd_t         cur_cmd;
  mem_pkg::word_idx_t    word_idx;
  logic [`MEM_LEN_W-1:0] beat_cnt;
  logic                  cmd_fire;
  logic                  w_fire;
  logic                  last_beat;

  // ------------------------------
  // Handshakes
  // ------------------------------
  assign cmd_ready_o = ~busy;
  assign cmd_fire    = cmd_valid_i & cmd_ready_o;
  // W only moves while the B line could take a response
  assign w_ready_o   = busy & b_ready_i;
  assign w_fire      = w_valid_i & w_ready_o;
  assign last_beat   = (beat_cnt == cur_cmd.len);

  always_ff @(posedge clk) begin
    if (rst)
      busy <= 1'b0;
    else if (cmd_fire)
      busy <= 1'b1;
    else if (w_fire && last_beat)
      busy <= 1'b0;
  end

  // Burst position
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      cur_cmd  <= cmd_i;
      word_idx <= cmd_i.addr[`MEM_ADDR_W-1 -: `MEM_IDX_W];
      beat_cnt <= '0;
    end else if (w_fire) begin
      word_idx <= word_idx + 1'b1;
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // ------------------------------
  // Array write and response
  // ------------------------------
  assign ram_wr_o.en   = w_fire;
  assign ram_wr_o.idx  = word_idx;
  assign ram_wr_o.data = w_i.data;
  assign ram_wr_o.strb = w_i.strb;

  // B goes out together with the final beat
  assign b_valid_o = w_fire & last_beat;
  assign b_o.id    = cur_cmd.id;
  assign b_o.resp  = axi_pkg::RESP_OKAY;

  a_wlast_match: assert property (@(posedge clk) disable iff (rst)
    w_fire |-> (w_i.last == last_beat))
    else $error("wlast does not match the AW burst length");

endmodule

// ==== verilog/rd_burst_engine.sv ====
// Read burst engine; one INCR burst at a time, a new command only after the last beat is taken
`timescale 1ns/1ps
`include "mem_config.svh"

module rd_burst_engine (
  input  logic                   clk,
  input  logic                   rst,
  input  axi_pkg::cmd_t          cmd_i,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  output mem_pkg::ram_rd_t       ram_rd_o,
  input  logic [`MEM_DATA_W-1:0] ram_rdata_i,
  output axi_pkg::r_beat_t       r_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i
);

  logic                  busy;
  axi_pkg::cmd_t         cur_cmd;
  mem_pkg::word_idx_t    word_idx;
  logic [`MEM_LEN_W-1:0] beat_cnt;
  logic                  cmd_fire;
  logic                  r_fire;
  logic                  last_beat;

  assign cmd_ready_o = ~busy;
  assign cmd_fire    = cmd_valid_i & cmd_ready_o;
  assign r_valid_o   = busy;
  assign r_fire      = r_valid_o & r_ready_i;
  assign last_beat   = (beat_cnt == cur_cmd.len);

  always_ff @(posedge clk) begin
    if (rst)
      busy <= 1'b0;
    else if (cmd_fire)
      busy <= 1'b1;
    else if (r_fire && last_beat)
      busy <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      cur_cmd  <= cmd_i;
      word_idx <= cmd_i.addr[`MEM_ADDR_W-1 -: `MEM_IDX_W];
      beat_cnt <= '0;
    end else if (r_fire) begin
      word_idx <= word_idx + 1'b1;
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // ------------------------------
  // Beat assembly
  // ------------------------------
  // Array read is combinational, data lines up with the current index
  assign ram_rd_o.idx = word_idx;
  assign r_o.id       = cur_cmd.id;
  assign r_o.data     = ram_rdata_i;
  assign r_o.resp     = axi_pkg::RESP_OKAY;
  assign r_o.last     = last_beat;

endmodule

// ==== verilog/mem_array.sv ====
// Word storage with no reset, contents start undefined; one byte-enabled write, one async read
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_array (
  input  logic                   clk,
  input  mem_pkg::ram_wr_t       ram_wr_i,
  input  mem_pkg::ram_rd_t       ram_rd_i,
  output logic [`MEM_DATA_W-1:0] ram_rdata_o
);

  logic [`MEM_DATA_W-1:0] mem_q [`MEM_WORDS];

  // ------------------------------
  // Write port
  // ------------------------------
  // Bytes merged under the strobe, other lanes keep their value
  always_ff @(posedge clk) begin
    if (ram_wr_i.en) begin
      for (int b = 0; b < `MEM_STRB_W; b++) begin
        if (ram_wr_i.strb[b])
          mem_q[ram_wr_i.idx][8*b +: 8] <= ram_wr_i.data[8*b +: 8];
      end
    end
  end

  // ------------------------------
  // Read port
  // ------------------------------
  // Same-cycle write to the same word is seen a cycle later
  assign ram_rdata_o = mem_q[ram_rd_i.idx];

endmodule

// ==== verilog/resp_delay_line.sv ====
// Fixed-latency pipe, LATENCY >= 1; a stalled output freezes all stages, bubbles are not squeezed
`timescale 1ns/1ps

module resp_delay_line #(
  parameter int WIDTH   = 6,
  parameter int LATENCY = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] in_data_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  output logic [WIDTH-1:0] out_data_o,
  output logic             out_valid_o,
  input  logic             out_ready_i
);

  logic [WIDTH-1:0]   stage_data [LATENCY];
  logic [LATENCY-1:0] stage_valid;
  logic               stall;

  assign out_valid_o = stage_valid[LATENCY-1];
  assign out_data_o  = stage_data[LATENCY-1];
  // Held item at the output blocks the whole pipe
  assign stall       = out_valid_o & ~out_ready_i;
  assign in_ready_o  = ~stall;

  // ------------------------------
  // Stage shift
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= '0;
    end else if (!stall) begin
      for (int i = LATENCY - 1; i > 0; i--)
        stage_valid[i] <= stage_valid[i-1];
      stage_valid[0] <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      for (int i = LATENCY - 1; i > 0; i--)
        stage_data[i] <= stage_data[i-1];
      stage_data[0] <= in_data_i;
    end
  end

  a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    stall |=> out_valid_o && $stable(out_data_o))
    else $error("delay line output changed while stalled");

endmodule

// ==== verilog/axi_mem_top.sv ====
// AXI4 slave memory model for simulation; INCR full-width bursts only, every response is OKAY
`timescale 1ns/1ps
`include "mem_config.svh"

module axi_mem_top (
  input  logic             clk,
  input  logic             rst,
  input  axi_pkg::cmd_t    aw_i,
  input  logic             aw_valid_i,
  output logic             aw_ready_o,
  input  axi_pkg::w_beat_t w_i,
  input  logic             w_valid_i,
  output logic             w_ready_o,
  output axi_pkg::b_resp_t b_o,
  output logic             b_valid_o,
  input  logic             b_ready_i,
  input  axi_pkg::cmd_t    ar_i,
  input  logic             ar_valid_i,
  output logic             ar_ready_o,
  output axi_pkg::r_beat_t r_o,
  output logic             r_valid_o,
  input  logic             r_ready_i
);

  axi_pkg::cmd_t          aw_cmd;
  logic                   aw_cmd_valid;
  logic                   aw_cmd_ready;
  axi_pkg::cmd_t          ar_cmd;
  logic                   ar_cmd_valid;
  logic                   ar_cmd_ready;
  mem_pkg::ram_wr_t       ram_wr;
  mem_pkg::ram_rd_t       ram_rd;
  logic [`MEM_DATA_W-1:0] ram_rdata;
  axi_pkg::b_resp_t       b_item;
  logic                   b_item_valid;
  logic                   b_item_ready;
  axi_pkg::r_beat_t       r_item;
  logic                   r_item_valid;
  logic                   r_item_ready;

  // ------------------------------
  // Write path
  // ------------------------------
  cmd_fifo #(.WIDTH($bits(axi_pkg::cmd_t)), .DEPTH(`MEM_CMD_DEPTH)) u_aw_fifo (
    .clk(clk), .rst(rst),
    .in_data_i(aw_i), .in_valid_i(aw_valid_i), .in_ready_o(aw_ready_o),
    .out_data_o(aw_cmd), .out_valid_o(aw_cmd_valid), .out_ready_i(aw_cmd_ready)
  );

  wr_burst_engine u_wr_engine (
    .clk(clk), .rst(rst),
    .cmd_i(aw_cmd), .cmd_valid_i(aw_cmd_valid), .cmd_ready_o(aw_cmd_ready),
    .w_i(w_i), .w_valid_i(w_valid_i), .w_ready_o(w_ready_o),
    .ram_wr_o(ram_wr),
    .b_o(b_item), .b_valid_o(b_item_valid), .b_ready_i(b_item_ready)
  );

  resp_delay_line #(.WIDTH($bits(axi_pkg::b_resp_t)), .LATENCY(`MEM_WR_LAT)) u_b_delay (
    .clk(clk), .rst(rst),
    .in_data_i(b_item), .in_valid_i(b_item_valid), .in_ready_o(b_item_ready),
    .out_data_o(b_o), .out_valid_o(b_valid_o), .out_ready_i(b_ready_i)
  );

  // ------------------------------
  // Storage
  // ------------------------------
  mem_array u_mem_array (
    .clk(clk), .ram_wr_i(ram_wr), .ram_rd_i(ram_rd), .ram_rdata_o(ram_rdata)
  );

  // ------------------------------
  // Read path
  // ------------------------------
  cmd_fifo #(.WIDTH($bits(axi_pkg::cmd_t)), .DEPTH(`MEM_CMD_DEPTH)) u_ar_fifo (
    .clk(clk), .rst(rst),
    .in_data_i(ar_i), .in_valid_i(ar_valid_i), .in_ready_o(ar_ready_o),
    .out_data_o(ar_cmd), .out_valid_o(ar_cmd_valid), .out_ready_i(ar_cmd_ready)
  );

  rd_burst_engine u_rd_engine (
    .clk(clk), .rst(rst),
    .cmd_i(ar_cmd), .cmd_valid_i(ar_cmd_valid), .cmd_ready_o(ar_cmd_ready),
    .ram_rd_o(ram_rd), .ram_rdata_i(ram_rdata),
    .r_o(r_item), .r_valid_o(r_item_valid), .r_ready_i(r_item_ready)
  );

  resp_delay_line #(.WIDTH($bits(axi_pkg::r_beat_t)), .LATENCY(`MEM_RD_LAT)) u_r_delay (
    .clk(clk), .rst(rst),
    .in_data_i(r_item), .in_valid_i(r_item_valid), .in_ready_o(r_item_ready),
    .out_data_o(r_o), .out_valid_o(r_valid_o), .out_ready_i(r_ready_i)
  );

endmodule

// ==== sim/tb_axi_mem_tasks.svh ====
// Checks and channel drivers for tb_axi_mem; drivers start and return 1 ns after a rising edge
`ifndef TB_AXI_MEM_TASKS_SVH
`define TB_AXI_MEM_TASKS_SVH

// ------------------------------
// Compare tasks
// ------------------------------
task automatic check_bit(input string name, input logic got, input logic exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
  end
endtask

task automatic check_b(input axi_pkg::b_resp_t got, input axi_pkg::b_resp_t exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("ERR t=%0t b_o got id=%h resp=%h exp id=%h resp=%h",
             $time, got.id, got.resp, exp.id, exp.resp);
  end
endtask

task automatic check_r(input axi_pkg::r_beat_t got, input axi_pkg::r_beat_t exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("ERR t=%0t r_o got id=%h data=%h resp=%h last=%b exp id=%h data=%h resp=%h last=%b",
             $time, got.id, got.data, got.resp, got.last,
             exp.id, exp.data, exp.resp, exp.last);
  end
endtask

// ------------------------------
// Reference memory
// ------------------------------
function automatic logic [`MEM_DATA_W-1:0] model_word(input int idx);
  logic [`MEM_DATA_W-1:0] word;
  for (int b = 0; b < `MEM_STRB_W; b++)
    word[8*b +: 8] = model_mem[idx*`MEM_STRB_W + b];
  return word;
endfunction

task automatic model_write(input int idx, input logic [`MEM_DATA_W-1:0] data,
                           input logic [`MEM_STRB_W-1:0] strb);
  for (int b = 0; b < `MEM_STRB_W; b++) begin
    if (strb[b])
      model_mem[idx*`MEM_STRB_W + b] = data[8*b +: 8];
  end
endtask

// Every word gets a distinct value, odd multiplier keeps it one-to-one
function automatic logic [`MEM_DATA_W-1:0] fill_word(input int idx);
  return `MEM_DATA_W'(idx * 32'h9e37_79b1 + 32'h1357_9bdf);
endfunction

function automatic axi_pkg::cmd_t random_cmd(input int max_len);
  axi_pkg::cmd_t c;
  c.id   = `MEM_ID_W'($urandom);
  c.addr = `MEM_ADDR_W'($urandom);
  c.len  = `MEM_LEN_W'($urandom % (max_len + 1));
  return c;
endfunction

// ------------------------------
// Channel drivers
// ------------------------------
task automatic send_aw(input axi_pkg::cmd_t c);
  axi_pkg::b_resp_t eb;
  aw       = c;
  aw_valid = 1'b1;
  @(negedge clk);
  while (!aw_ready) begin
    aw_low_seen = 1'b1;
    @(negedge clk);
  end
  eb.id   = c.id;
  eb.resp = axi_pkg::RESP_OKAY;
  exp_b.push_back(eb);
  @(posedge clk);
  #1;
  aw_valid = 1'b0;
endtask

task automatic send_w_burst(input axi_pkg::cmd_t c, input bit fill);
  int base;
  int idx;
  base = c.addr / `MEM_STRB_W;
  for (int beat = 0; beat <= c.len; beat++) begin
    idx     = (base + beat) % `MEM_WORDS;
    w.data  = fill ? fill_word(idx) : `MEM_DATA_W'($urandom);
    w.strb  = fill ? '1 : `MEM_STRB_W'($urandom);
    w.last  = (beat == c.len);
    w_valid = 1'b1;
    @(negedge clk);
    while (!w_ready)
      @(negedge clk);
    model_write(idx, w.data, w.strb);
    @(posedge clk);
    #1;
  end
  w_valid = 1'b0;
endtask

task automatic write_burst(input axi_pkg::cmd_t c, input bit fill);
  fork
    send_aw(c);
    send_w_burst(c, fill);
  join
endtask

// Expected beats come from the model as it stands when the AR is issued
task automatic send_ar(input axi_pkg::cmd_t c);
  axi_pkg::r_beat_t rb;
  int base;
  base = c.addr / `MEM_STRB_W;
  for (int beat = 0; beat <= c.len; beat++) begin
    rb.id   = c.id;
    rb.data = model_word((base + beat) % `MEM_WORDS);
    rb.resp = axi_pkg::RESP_OKAY;
    rb.last = (beat == c.len);
    exp_r.push_back(rb);
  end
  ar       = c;
  ar_valid = 1'b1;
  @(negedge clk);
  while (!ar_ready)
    @(negedge clk);
  @(posedge clk);
  #1;
  ar_valid = 1'b0;
endtask

task automatic wait_idle();
  while (exp_b.size() != 0 || exp_r.size() != 0) begin
    @(posedge clk);
    #1;
  end
  repeat (2) @(posedge clk);
  #1;
endtask

`endif

// ==== sim/tb_axi_mem.sv ====
// Testbench for axi_mem_top; memory is filled before any read since the array has no reset
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_axi_mem;

  localparam int N_RAND    = 16;
  localparam int N_THROT   = 10;
  localparam int N_QUEUED  = `MEM_CMD_DEPTH + 2;
  // fill, writes, reads, throttled pairs, queued AWs, wrap write and two reads
  localparam int N_BURSTS  = 4 + 2 * N_RAND + 2 * N_THROT + N_QUEUED + 3;
  localparam int WD_CYCLES = N_BURSTS * (256 + `MEM_WR_LAT + `MEM_RD_LAT + 64);

  logic             clk;
  logic             rst;
  axi_pkg::cmd_t    aw;
  logic             aw_valid;
  logic             aw_ready;
  axi_pkg::w_beat_t w;
  logic             w_valid;
  logic             w_ready;
  axi_pkg::b_resp_t b;
  logic             b_valid;
  logic             b_ready;
  axi_pkg::cmd_t    ar;
  logic             ar_valid;
  logic             ar_ready;
  axi_pkg::r_beat_t r;
  logic             r_valid;
  logic             r_ready;

  logic [7:0]       model_mem [`MEM_WORDS * `MEM_STRB_W];
  axi_pkg::b_resp_t exp_b [$];
  axi_pkg::r_beat_t exp_r [$];
  logic             throttle;
  logic             aw_low_seen;
  int               n_tests;
  int               n_checks;
  int               n_errors;
  int               test_err_base;

  `include "tb_axi_mem_tasks.svh"

  task automatic start_test();
    test_err_base = n_errors;
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    $display("test %0d %-20s %s (%0d errors)", n_tests, name,
             (n_errors == test_err_base) ? "ok" : "fail", n_errors - test_err_base);
  endtask

  axi_mem_top u_axi_mem_top (
    .clk(clk), .rst(rst),
    .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
    .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
    .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready),
    .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
    .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Response ready, random when throttled
  initial begin
    forever begin
      @(posedge clk);
      #1;
      b_ready = throttle ? 1'($urandom) : 1'b1;
      r_ready = throttle ? 1'($urandom) : 1'b1;
    end
  end

  // ------------------------------
  // Response monitors
  // ------------------------------
  // Sampled mid-cycle, a handshake seen here completes at the next edge
  initial begin
    forever begin
      @(negedge clk);
      if (!rst && b_valid && b_ready) begin
        if (exp_b.size() == 0) begin
          n_errors++;
          $display("B response at %0t with no write burst outstanding", $time);
        end else begin
          check_b(b, exp_b.pop_front());
        end
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      if (!rst && r_valid && r_ready) begin
        if (exp_r.size() == 0) begin
          n_errors++;
          $display("R beat at %0t with no read beat outstanding", $time);
        end else begin
          check_r(r, exp_r.pop_front());
        end
      end
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, responses still missing", WD_CYCLES);
    $display("tests failed");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    axi_pkg::cmd_t c;
    axi_pkg::cmd_t cmds [N_QUEUED];
    int            wait_cnt;

    rst = 1'b1;
    aw = '0;
    aw_valid = 1'b0;
    w = '0;
    w_valid = 1'b0;
    b_ready = 1'b0;
    ar = '0;
    ar_valid = 1'b0;
    r_ready = 1'b0;
    throttle = 1'b0;
    aw_low_seen = 1'b0;
    n_tests = 0;
    n_checks = 0;
    n_errors = 0;
    void'($urandom(32'h9f80));
    for (int i = 0; i < `MEM_WORDS * `MEM_STRB_W; i++)
      model_mem[i] = 8'h00;

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    start_test();
    @(negedge clk);
    check_bit("b_valid_o", b_valid, 1'b0);
    check_bit("r_valid_o", r_valid, 1'b0);
    check_bit("aw_ready_o", aw_ready, 1'b1);
    check_bit("ar_ready_o", ar_ready, 1'b1);
    check_bit("w_ready_o", w_ready, 1'b0);
    @(posedge clk);
    #1;
    finish_test("reset state");

    // Four full-length bursts cover every word
    start_test();
    for (int k = 0; k < 4; k++) begin
      c.id   = `MEM_ID_W'(k);
      c.addr = `MEM_ADDR_W'(k * 256 * `MEM_STRB_W);
      c.len  = 8'd255;
      write_burst(c, 1'b1);
    end
    wait_idle();
    finish_test("memory fill");

    start_test();
    for (int k = 0; k < N_RAND; k++)
      write_burst(random_cmd(15), 1'b0);
    wait_idle();
    finish_test("random writes");

    start_test();
    for (int k = 0; k < N_RAND; k++)
      send_ar(random_cmd(15));
    wait_idle();
    finish_test("random reads");

    start_test();
    throttle = 1'b1;
    for (int k = 0; k < N_THROT; k++)
      write_burst(random_cmd(15), 1'b0);
    wait_idle();
    for (int k = 0; k < N_THROT; k++)
      send_ar(random_cmd(15));
    wait_idle();
    throttle = 1'b0;
    finish_test("back-pressure");

    // W held back until the AW FIFO fills
    start_test();
    for (int k = 0; k < N_QUEUED; k++)
      cmds[k] = random_cmd(7);
    aw_low_seen = 1'b0;
    fork
      for (int k = 0; k < N_QUEUED; k++)
        send_aw(cmds[k]);
      begin
        wait_cnt = 0;
        while (!aw_low_seen && wait_cnt < 40) begin
          @(posedge clk);
          #1;
          wait_cnt++;
        end
        for (int k = 0; k < N_QUEUED; k++)
          send_w_burst(cmds[k], 1'b0);
      end
    join
    wait_idle();
    n_checks++;
    if (!aw_low_seen) begin
      n_errors++;
      $display("awready stayed high with %0d commands queued and no W data", N_QUEUED);
    end
    finish_test("command queue full");

    start_test();
    c.id   = `MEM_ID_W'($urandom);
    c.addr = `MEM_ADDR_W'((`MEM_WORDS - 3) * `MEM_STRB_W);
    c.len  = 8'd7;
    write_burst(c, 1'b0);
    wait_idle();
    send_ar(c);
    c.addr = '0;
    c.len  = 8'd4;
    send_ar(c);
    wait_idle();
    finish_test("address wrap");

    $display("%0d tests run, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verilog
+incdir+sim
verilog/axi_pkg.sv
verilog/mem_pkg.sv
verilog/cmd_fifo.sv
verilog/wr_burst_engine.sv
verilog/rd_burst_engine.sv
verilog/mem_array.sv
verilog/resp_delay_line.sv
verilog/axi_mem_top.sv
sim/tb_axi_mem.sv
